//--- project.f
rtl/mem_pkg.sv
rtl/sdpram32.sv
rtl/mem_port_bram.sv
rtl/mem_port_arbiter.sv
rtl/mem_fill_engine.sv
rtl/mem_sum_engine.sv
rtl/mem_subsys.sv
sim/mem_subsys_assert.sv
sim/tb_mem_subsys.sv

//--- rtl/mem_fill_engine.sv
`timescale 1ns/1ps

module mem_fill_engine #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] base_addr,
    input  logic [ADDR_WIDTH:0]   word_count,
    input  logic [31:0]           seed_value,
    output logic                  busy,
    output logic                  done,
    output mem_pkg::mem_req_t     req,
    input  mem_pkg::mem_rsp_t     rsp
);

    mem_pkg::eng_state_t   state_q;
    logic [ADDR_WIDTH:0]   left_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [31:0]           data_q;

    // Control FSM
    // A start with a zero count finishes at once without touching memory
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mem_pkg::ENG_IDLE;
            left_q  <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                mem_pkg::ENG_IDLE: begin
                    if (start) begin
                        left_q <= word_count;
                        if (word_count == '0) begin
                            done <= 1'b1;
                        end else begin
                            state_q <= mem_pkg::ENG_REQ;
                        end
                    end
                end
                mem_pkg::ENG_REQ: begin
                    if (rsp.ready) begin
                        left_q <= left_q - 1'b1;
                        if (left_q == (ADDR_WIDTH+1)'(1)) begin
                            state_q <= mem_pkg::ENG_IDLE;
                            done    <= 1'b1;
                        end else begin
                            state_q <= mem_pkg::ENG_WAIT;
                        end
                    end
                end
                // Request stays low for one cycle after each ready
                default: state_q <= mem_pkg::ENG_REQ;
            endcase
        end
    end

    // Address and pattern advance together, so data is seed plus index
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::ENG_IDLE && start) begin
            addr_q <= base_addr;
            data_q <= seed_value;
        end else if (state_q == mem_pkg::ENG_REQ && rsp.ready) begin
            addr_q <= addr_q + 1'b1;
            data_q <= data_q + 32'd1;
        end
    end

    assign busy = (state_q != mem_pkg::ENG_IDLE);

    // Full-word writes only
    always_comb begin
        req         = '0;
        req.wr      = (state_q == mem_pkg::ENG_REQ);
        req.addr    = 16'(addr_q);
        req.data    = data_q;
        req.byte_en = 4'hf;
    end

endmodule

//--- rtl/mem_pkg.sv
package mem_pkg;

    // Number of peer clients that share the memory
    localparam int NUM_CLIENTS = 3;

    // Request from a client, and also the strobe the arbiter issues to the memory
    // A client raises rd or wr as a level and holds every field until ready
    typedef struct packed {
        logic        rd;
        logic        wr;
        // Word address, only the low ADDR_WIDTH bits select a word
        logic [15:0] addr;
        logic [31:0] data;
        // One enable per byte lane of data
        logic [3:0]  byte_en;
    } mem_req_t;

    // Response to a client
    // Ready is a single-cycle pulse and q is only meaningful with a read ready
    typedef struct packed {
        logic        ready;
        logic [31:0] q;
    } mem_rsp_t;

    // Client identity, in priority order with the host first
    // The arbiter also uses it as the owner tag of a read in flight
    typedef enum logic [1:0] {
        CLIENT_HOST = 2'd0,
        CLIENT_FILL = 2'd1,
        CLIENT_SUM  = 2'd2
    } mem_client_e;

    // State of the fill and checksum engines
    // ENG_REQ holds the request up, ENG_WAIT drops it for one cycle after ready
    typedef enum logic [1:0] {
        ENG_IDLE = 2'd0,
        ENG_REQ  = 2'd1,
        ENG_WAIT = 2'd2
    } eng_state_t;

endpackage

//--- rtl/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t host_req,
    input  mem_pkg::mem_req_t fill_req,
    input  mem_pkg::mem_req_t sum_req,
    output mem_pkg::mem_rsp_t host_rsp,
    output mem_pkg::mem_rsp_t fill_rsp,
    output mem_pkg::mem_rsp_t sum_rsp,
    output mem_pkg::mem_req_t wr_req,
    input  mem_pkg::mem_rsp_t wr_rsp,
    output mem_pkg::mem_req_t rd_req,
    input  mem_pkg::mem_rsp_t rd_rsp
);

    localparam int N = mem_pkg::NUM_CLIENTS;

    mem_pkg::mem_req_t    req [N];
    mem_pkg::mem_rsp_t    rsp [N];
    logic [N-1:0]         issued_q;
    logic [N-1:0]         wr_cand;
    logic [N-1:0]         rd_cand;
    logic [N-1:0]         wr_gnt;
    logic [N-1:0]         rd_gnt;
    logic [N-1:0]         wr_done;
    logic [N-1:0]         rd_done;
    mem_pkg::mem_client_e wr_win;
    mem_pkg::mem_client_e rd_win;
    logic                 wr_own_vld_q;
    mem_pkg::mem_client_e wr_own_q;
    logic [1:0]           tag_vld_q;
    mem_pkg::mem_client_e tag_q [2];

    // Lowest set candidate bit is the highest priority client
    function automatic mem_pkg::mem_client_e pick(input logic [N-1:0] cand);
        mem_pkg::mem_client_e win;
        win = mem_pkg::CLIENT_HOST;
        for (int i = N - 1; i >= 0; i--) begin
            if (cand[i]) begin
                win = mem_pkg::mem_client_e'(i);
            end
        end
        return win;
    endfunction

    // Clients laid out by their tag so the tag indexes them directly
    assign req[mem_pkg::CLIENT_HOST] = host_req;
    assign req[mem_pkg::CLIENT_FILL] = fill_req;
    assign req[mem_pkg::CLIENT_SUM]  = sum_req;

    // A held request is a candidate only until it has been issued once
    always_comb begin
        for (int i = 0; i < N; i++) begin
            wr_cand[i] = req[i].wr & ~issued_q[i];
            rd_cand[i] = req[i].rd & ~issued_q[i];
        end
    end

    // Write and read ports are scheduled independently of each other
    assign wr_gnt = wr_cand & ~(wr_cand - 1'b1);
    assign rd_gnt = rd_cand & ~(rd_cand - 1'b1);
    assign wr_win = pick(wr_cand);
    assign rd_win = pick(rd_cand);

    // The winning level becomes a single-cycle strobe at the memory
    always_comb begin
        wr_req = '0;
        rd_req = '0;
        if (|wr_gnt) begin
            wr_req    = req[wr_win];
            wr_req.rd = 1'b0;
        end
        if (|rd_gnt) begin
            rd_req    = req[rd_win];
            rd_req.wr = 1'b0;
        end
    end

    // Issued flag is set by a grant and cleared by the ready that ends it
    // Grant and ready cannot meet on one client because ready needs the flag set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issued_q     <= '0;
            wr_own_vld_q <= 1'b0;
            tag_vld_q    <= '0;
        end else begin
            issued_q     <= (issued_q | wr_gnt | rd_gnt) & ~(wr_done | rd_done);
            wr_own_vld_q <= |wr_gnt;
            tag_vld_q    <= {tag_vld_q[0], |rd_gnt};
        end
    end

    // Write owner is held one cycle, read tags shift along with the RAM pipeline
    always_ff @(posedge clk) begin
        wr_own_q <= wr_win;
        tag_q[0] <= rd_win;
        tag_q[1] <= tag_q[0];
    end

    // Responses go to the owner of the write or to the tag leaving the shift register
    always_comb begin
        for (int i = 0; i < N; i++) begin
            wr_done[i]   = wr_rsp.ready & wr_own_vld_q & (wr_own_q == i);
            rd_done[i]   = rd_rsp.ready & tag_vld_q[1] & (tag_q[1] == i);
            rsp[i].ready = wr_done[i] | rd_done[i];
            rsp[i].q     = rd_done[i] ? rd_rsp.q : wr_rsp.q;
        end
    end

    assign host_rsp = rsp[mem_pkg::CLIENT_HOST];
    assign fill_rsp = rsp[mem_pkg::CLIENT_FILL];
    assign sum_rsp  = rsp[mem_pkg::CLIENT_SUM];

endmodule

//--- rtl/mem_port_bram.sv
`timescale 1ns/1ps

module mem_port_bram #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t wr_req,
    output mem_pkg::mem_rsp_t wr_rsp,
    input  mem_pkg::mem_req_t rd_req,
    output mem_pkg::mem_rsp_t rd_rsp
);

    logic [31:0] ram_q;
    logic        wr_ready_q;
    logic        rd_pend_q;
    logic        rd_ready_q;

    // One port of the RAM is dedicated to writes, the other to reads
    // Only the low ADDR_WIDTH bits of the word address reach the array
    sdpram32 #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_ram (
        .clk         (clk),
        .write_addr  (wr_req.addr[ADDR_WIDTH-1:0]),
        .write_data  (wr_req.data),
        .write_enable(wr_req.wr),
        .byte_enable (wr_req.byte_en),
        .read_addr   (rd_req.addr[ADDR_WIDTH-1:0]),
        .read_enable (rd_req.rd),
        .read_data   (ram_q)
    );

    // Write ready follows the strobe by one cycle
    // Read ready goes through two stages to line up with the RAM pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ready_q <= 1'b0;
            rd_pend_q  <= 1'b0;
            rd_ready_q <= 1'b0;
        end else begin
            wr_ready_q <= wr_req.wr;
            rd_pend_q  <= rd_req.rd;
            rd_ready_q <= rd_pend_q;
        end
    end

    // A write carries no data back
    assign wr_rsp.ready = wr_ready_q;
    assign wr_rsp.q     = '0;
    assign rd_rsp.ready = rd_ready_q;
    assign rd_rsp.q     = ram_q;

endmodule

//--- rtl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pkg::mem_req_t     host_req,
    output mem_pkg::mem_rsp_t     host_rsp,
    input  logic                  fill_start,
    input  logic [ADDR_WIDTH-1:0] fill_base,
    input  logic [ADDR_WIDTH:0]   fill_count,
    input  logic [31:0]           fill_seed,
    output logic                  fill_busy,
    output logic                  fill_done,
    input  logic                  sum_start,
    input  logic [ADDR_WIDTH-1:0] sum_base,
    input  logic [ADDR_WIDTH:0]   sum_count,
    output logic                  sum_busy,
    output logic                  sum_done,
    output logic [31:0]           sum_value
);

    // Engine requests and responses
    mem_pkg::mem_req_t fill_req;
    mem_pkg::mem_rsp_t fill_rsp;
    mem_pkg::mem_req_t sum_req;
    mem_pkg::mem_rsp_t sum_rsp;

    // Strobes and responses between the arbiter and the memory
    mem_pkg::mem_req_t wr_req;
    mem_pkg::mem_rsp_t wr_rsp;
    mem_pkg::mem_req_t rd_req;
    mem_pkg::mem_rsp_t rd_rsp;

    // Host has top priority, then fill, then sum
    mem_port_arbiter u_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .host_req(host_req),
        .fill_req(fill_req),
        .sum_req (sum_req),
        .host_rsp(host_rsp),
        .fill_rsp(fill_rsp),
        .sum_rsp (sum_rsp),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp)
    );

    mem_port_bram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_bram (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_req(wr_req),
        .wr_rsp(wr_rsp),
        .rd_req(rd_req),
        .rd_rsp(rd_rsp)
    );

    mem_fill_engine #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_fill (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (fill_start),
        .base_addr (fill_base),
        .word_count(fill_count),
        .seed_value(fill_seed),
        .busy      (fill_busy),
        .done      (fill_done),
        .req       (fill_req),
        .rsp       (fill_rsp)
    );

    mem_sum_engine #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_sum (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (sum_start),
        .base_addr (sum_base),
        .word_count(sum_count),
        .busy      (sum_busy),
        .done      (sum_done),
        .sum       (sum_value),
        .req       (sum_req),
        .rsp       (sum_rsp)
    );

endmodule

//--- rtl/mem_sum_engine.sv
`timescale 1ns/1ps

module mem_sum_engine #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic [ADDR_WIDTH-1:0] base_addr,
    input  logic [ADDR_WIDTH:0]   word_count,
    output logic                  busy,
    output logic                  done,
    output logic [31:0]           sum,
    output mem_pkg::mem_req_t     req,
    input  mem_pkg::mem_rsp_t     rsp
);

    mem_pkg::eng_state_t   state_q;
    logic [ADDR_WIDTH:0]   left_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [31:0]           acc_q;

    // Control FSM and accumulator
    // The sum is cleared on start and then held after done until the next start
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= mem_pkg::ENG_IDLE;
            left_q  <= '0;
            acc_q   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state_q)
                mem_pkg::ENG_IDLE: begin
                    if (start) begin
                        left_q <= word_count;
                        acc_q  <= '0;
                        if (word_count == '0) begin
                            done <= 1'b1;
                        end else begin
                            state_q <= mem_pkg::ENG_REQ;
                        end
                    end
                end
                mem_pkg::ENG_REQ: begin
                    if (rsp.ready) begin
                        // Add wraps modulo 2**32
                        acc_q  <= acc_q + rsp.q;
                        left_q <= left_q - 1'b1;
                        if (left_q == (ADDR_WIDTH+1)'(1)) begin
                            state_q <= mem_pkg::ENG_IDLE;
                            done    <= 1'b1;
                        end else begin
                            state_q <= mem_pkg::ENG_WAIT;
                        end
                    end
                end
                // One idle cycle between reads, then the next address goes out
                default: state_q <= mem_pkg::ENG_REQ;
            endcase
        end
    end

    // Read address walks up from the base
    always_ff @(posedge clk) begin
        if (state_q == mem_pkg::ENG_IDLE && start) begin
            addr_q <= base_addr;
        end else if (state_q == mem_pkg::ENG_REQ && rsp.ready) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign busy = (state_q != mem_pkg::ENG_IDLE);
    assign sum  = acc_q;

    // Read request, write fields left at zero
    always_comb begin
        req      = '0;
        req.rd   = (state_q == mem_pkg::ENG_REQ);
        req.addr = 16'(addr_q);
    end

endmodule

//--- rtl/sdpram32.sv
`timescale 1ns/1ps

module sdpram32 #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] write_addr,
    input  logic [31:0]           write_data,
    input  logic                  write_enable,
    input  logic [3:0]            byte_enable,
    input  logic [ADDR_WIDTH-1:0] read_addr,
    input  logic                  read_enable,
    output logic [31:0]           read_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Word array, 32 bits wide, four byte lanes per word
    logic [31:0] mem [DEPTH];

    // First read stage, the registered array output
    logic [31:0] array_q;

    // Write port
    // Each byte lane is written only when its enable is set
    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byte_enable[lane]) begin
                    mem[write_addr][lane*8 +: 8] <= write_data[lane*8 +: 8];
                end
            end
        end
    end

    // Read port, first stage
    // The array is sampled only on a read strobe so the value stays put otherwise
    always_ff @(posedge clk) begin
        if (read_enable) begin
            array_q <= mem[read_addr];
        end
    end

    // Read port, second stage
    // This output register gives the second cycle of read latency
    always_ff @(posedge clk) begin
        read_data <= array_q;
    end

endmodule

//--- sim/mem_subsys_assert.sv
`timescale 1ns/1ps

module mem_subsys_assert (
    input logic              clk,
    input logic              rst_n,
    input mem_pkg::mem_req_t host_req,
    input mem_pkg::mem_rsp_t host_rsp,
    input mem_pkg::mem_req_t fill_req,
    input mem_pkg::mem_rsp_t fill_rsp,
    input mem_pkg::mem_req_t sum_req,
    input mem_pkg::mem_rsp_t sum_rsp
);

    // Failures seen by the properties below, read by the testbench at the end
    int unsigned fail_count = 0;

    // The host always wins, so its write ready follows the rising wr by one cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(host_req.wr) |=> host_rsp.ready)
    else begin
        fail_count++;
        $error("host write ready did not arrive one cycle after wr rose");
    end

    // A host read takes exactly two cycles, with no early ready
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(host_req.rd) |=> !host_rsp.ready ##1 host_rsp.ready)
    else begin
        fail_count++;
        $error("host read ready did not arrive exactly two cycles after rd rose");
    end

    // Each client holds its request steady until its ready comes back
    assert property (@(posedge clk) disable iff (!rst_n)
        (host_req.rd || host_req.wr) && !host_rsp.ready |=> $stable(host_req))
    else begin
        fail_count++;
        $error("host request changed before its ready");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (fill_req.rd || fill_req.wr) && !fill_rsp.ready |=> $stable(fill_req))
    else begin
        fail_count++;
        $error("fill engine request changed before its ready");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (sum_req.rd || sum_req.wr) && !sum_rsp.ready |=> $stable(sum_req))
    else begin
        fail_count++;
        $error("sum engine request changed before its ready");
    end

    // The host port never asks for a read and a write at once
    assert property (@(posedge clk) disable iff (!rst_n)
        !(host_req.rd && host_req.wr))
    else begin
        fail_count++;
        $error("the host raised rd and wr together");
    end

    // A ready routed to a client that is not waiting means a wrong owner tag
    assert property (@(posedge clk) disable iff (!rst_n)
        (!host_rsp.ready || host_req.rd || host_req.wr)
            && (!fill_rsp.ready || fill_req.wr)
            && (!sum_rsp.ready || sum_req.rd))
    else begin
        fail_count++;
        $error("a ready pulse reached a client with no request held");
    end

endmodule

bind mem_subsys mem_subsys_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .host_req(host_req),
    .host_rsp(host_rsp),
    .fill_req(fill_req),
    .fill_rsp(fill_rsp),
    .sum_req (sum_req),
    .sum_rsp (sum_rsp)
);

//--- sim/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int ADDR_WIDTH = 10;
    // The whole run needs well under a thousand cycles, so this leaves ample margin
    localparam int MAX_CYCLES = 4000;

    logic                  clk;
    logic                  rst_n;
    mem_pkg::mem_req_t     host_req;
    mem_pkg::mem_rsp_t     host_rsp;
    logic                  fill_start;
    logic [ADDR_WIDTH-1:0] fill_base;
    logic [ADDR_WIDTH:0]   fill_count;
    logic [31:0]           fill_seed;
    logic                  fill_busy;
    logic                  fill_done;
    logic                  sum_start;
    logic [ADDR_WIDTH-1:0] sum_base;
    logic [ADDR_WIDTH:0]   sum_count;
    logic                  sum_busy;
    logic                  sum_done;
    logic [31:0]           sum_value;

    // Reference copy of the memory, written by the testbench's own rules
    logic [31:0] model [2**ADDR_WIDTH];
    int          value_errors = 0;
    int          timeouts = 0;
    int          cycle_count = 0;

    mem_subsys #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("** Error at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // Only the enabled byte lanes take the new data
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [3:0] byte_en);
        logic [31:0] result;
        result = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            if (byte_en[lane]) result[lane*8 +: 8] = data[lane*8 +: 8];
        end
        return result;
    endfunction

    // Drive one host request, hold it through its ready cycle and count the cycles it took
    task automatic host_access(input logic rd, input int addr, input logic [31:0] data,
                               input logic [3:0] byte_en, output logic [31:0] q,
                               output int latency);
        @(negedge clk);
        host_req         = '0;
        host_req.rd      = rd;
        host_req.wr      = !rd;
        host_req.addr    = 16'(addr);
        host_req.data    = data;
        host_req.byte_en = byte_en;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!host_rsp.ready);
        q = host_rsp.q;
        // The request drops in the cycle after ready, as the engines do
        @(negedge clk);
        host_req = '0;
    endtask

    task automatic host_write(input int addr, input logic [31:0] data,
                              input logic [3:0] byte_en);
        logic [31:0] unused_q;
        int          latency;
        model[addr] = merge_lanes(model[addr], data, byte_en);
        host_access(1'b0, addr, data, byte_en, unused_q, latency);
        check_value("host_rsp.ready write latency", 32'd1, latency);
    endtask

    task automatic read_and_check(input int addr);
        logic [31:0] q;
        int          latency;
        host_access(1'b1, addr, '0, 4'h0, q, latency);
        check_value("host_rsp.ready read latency", 32'd2, latency);
        check_value($sformatf("host_rsp.q at word %0d", addr), model[addr], q);
    endtask

    // The model takes the fill pattern up front since nobody reads the range meanwhile
    task automatic run_fill(input int base, input int count, input logic [31:0] seed);
        for (int i = 0; i < count; i++) model[base + i] = seed + 32'(i);
        @(negedge clk);
        fill_base  = ADDR_WIDTH'(base);
        fill_count = (ADDR_WIDTH+1)'(count);
        fill_seed  = seed;
        fill_start = 1'b1;
        @(negedge clk);
        fill_start = 1'b0;
        check_value("fill_busy after start", 32'd1, fill_busy);
        while (!fill_done) @(negedge clk);
        check_value("fill_busy with done", 32'd0, fill_busy);
    endtask

    task automatic run_sum(input int base, input int count);
        logic [31:0] expected;
        expected = '0;
        for (int i = 0; i < count; i++) expected = expected + model[base + i];
        @(negedge clk);
        sum_base  = ADDR_WIDTH'(base);
        sum_count = (ADDR_WIDTH+1)'(count);
        sum_start = 1'b1;
        @(negedge clk);
        sum_start = 1'b0;
        check_value("sum_busy after start", 32'd1, sum_busy);
        while (!sum_done) @(negedge clk);
        check_value("sum_busy with done", 32'd0, sum_busy);
        check_value("sum_value", expected, sum_value);
    endtask

    task automatic print_counts();
        $display("Errors: %0d value, %0d assertion, %0d timeout",
                 value_errors, dut0.u_assert.fail_count, timeouts);
    endtask

    // Cycle counter that ends a stuck run
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            timeouts++;
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            print_counts();
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(29651));
        rst_n = 1'b0;
        host_req = '0;
        fill_start = 1'b0;
        fill_base = '0;
        fill_count = '0;
        fill_seed = '0;
        sum_start = 1'b0;
        sum_base = '0;
        sum_count = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Full words first so later partial writes merge into known data
        for (int i = 0; i < 16; i++) host_write(i, $urandom(), 4'hf);
        for (int i = 0; i < 24; i++) host_write($urandom_range(15, 0), $urandom(),
                                                4'($urandom_range(15, 1)));
        for (int i = 0; i < 16; i++) read_and_check(i);

        // Fill alone, then read the pattern back through the host
        run_fill(64, 32, $urandom());
        for (int i = 64; i < 96; i++) read_and_check(i);

        // Sum over the range the host wrote
        run_sum(0, 16);

        // Both engines and the host compete, reads from sum and host overlap in flight
        fork
            run_fill(128, 24, $urandom());
            run_sum(64, 32);
            begin
                for (int i = 200; i < 216; i++) host_write(i, $urandom(), 4'hf);
                for (int i = 200; i < 216; i++) read_and_check(i);
            end
        join
        for (int i = 128; i < 152; i++) read_and_check(i);
        run_sum(128, 24);

        repeat (4) @(negedge clk);
        print_counts();
        if (value_errors == 0 && dut0.u_assert.fail_count == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
